// File: compile.f
common/regread_pkg.sv
regfile/read_select.sv
regfile/preg_file.sv
regfile/wb_bypass.sv
logic/reg_read_top.sv
bench/reg_read_props.sv
bench/reg_read_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS = --binary --timing --assert -j 0
TOP = reg_read_tb
FILE_LIST = compile.f

OBJ_DIR = obj_dir
SIM_BIN = $(OBJ_DIR)/V$(TOP)
SOURCES = $(shell grep -v '^+' $(FILE_LIST))

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILE_LIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILE_LIST)

# pass only when the testbench printed its pass line
run: $(SIM_BIN)
	@out="$$($(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qx "Done: no errors"

clean:
	rm -rf $(OBJ_DIR)

// File: bench/reg_read_tb.sv
`timescale 1ns/1ps
`default_nettype none

module reg_read_tb;

    localparam int alu_ports = 3;
    localparam int load_ports = 2;
    localparam int store_ports = 1;
    localparam int wb_ports = 4;
    localparam int preg_count = 64;

    localparam int clk_period = 20;
    localparam int reset_cycles = 3;
    localparam int zero_cycles = 8;
    localparam int write_cycles = 40;
    localparam int read_cycles = 20;
    localparam int bypass_rounds = 4;
    localparam int random_cycles = 400;
    localparam int total_cycles = reset_cycles + zero_cycles + write_cycles + 2 + read_cycles
        + 2 * bypass_rounds + 6 + random_cycles + 3 + 50;  // 50 cycles of margin

    logic clk;
    logic reset;
    regread_pkg::src2_req_t alu_req [alu_ports];
    regread_pkg::src2_req_t csr_req;
    regread_pkg::src2_req_t mul_req;
    regread_pkg::src1_req_t load_req [load_ports];
    regread_pkg::src2_req_t store_req [store_ports];
    regread_pkg::wb_t wb [wb_ports];
    logic [alu_ports-1:0] alu_ready;
    logic csr_ready;
    logic mul_ready;
    regread_pkg::opnd2_t alu_opnd [alu_ports];
    regread_pkg::opnd2_t csr_opnd;
    regread_pkg::opnd2_t mul_opnd;
    regread_pkg::opnd1_t load_opnd [load_ports];
    regread_pkg::opnd2_t store_opnd [store_ports];

    regread_pkg::data_t model [preg_count];  // mirror of the register file
    regread_pkg::src2_req_t pend_alu [alu_ports];
    regread_pkg::src2_req_t pend_csr;
    regread_pkg::src2_req_t pend_mul;
    regread_pkg::src1_req_t pend_load [load_ports];
    regread_pkg::src2_req_t pend_store [store_ports];
    logic [15:0] lfsr_state;
    logic checking;
    string test_name;
    string pend_test;
    int error_count;
    int check_count;

    reg_read_top #(
        .alu_ports(alu_ports),
        .load_ports(load_ports),
        .store_ports(store_ports),
        .wb_ports(wb_ports),
        .preg_count(preg_count)
    ) UUT (
        .clk(clk),
        .reset(reset),
        .alu_req(alu_req),
        .csr_req(csr_req),
        .mul_req(mul_req),
        .load_req(load_req),
        .store_req(store_req),
        .alu_ready(alu_ready),
        .csr_ready(csr_ready),
        .mul_ready(mul_ready),
        .wb(wb),
        .alu_opnd(alu_opnd),
        .csr_opnd(csr_opnd),
        .mul_opnd(mul_opnd),
        .load_opnd(load_opnd),
        .store_opnd(store_opnd)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // **************************************************
    // random source and reference model
    // **************************************************

    function automatic logic rand_bit();
        logic out;
        out = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (out) begin
            lfsr_state = lfsr_state ^ 16'hB400;  // x^16 + x^14 + x^13 + x^11 + 1
        end
        return out;
    endfunction

    function automatic regread_pkg::preg_t rand_preg();
        regread_pkg::preg_t r;
        for (int b = 0; b < regread_pkg::PREG_BITS; b++) begin
            r[b] = rand_bit();
        end
        return r;
    endfunction

    function automatic regread_pkg::data_t rand_data();
        regread_pkg::data_t d;
        for (int b = 0; b < regread_pkg::XLEN; b++) begin
            d[b] = rand_bit();
        end
        return d;
    endfunction

    // value a read of r sees this cycle, with writes of this cycle forwarded
    function automatic regread_pkg::data_t expected_value(regread_pkg::preg_t r);
        regread_pkg::data_t v;
        if (r == '0) begin
            return '0;
        end
        v = model[r];
        for (int w = 0; w < wb_ports; w++) begin
            if (wb[w].en && wb[w].we && wb[w].rd == r) begin
                v = wb[w].res;  // a higher port overrides a lower one
            end
        end
        return v;
    endfunction

    // **************************************************
    // request latch and compare
    // **************************************************

    always @(posedge clk) begin
        pend_test = test_name;
        for (int i = 0; i < alu_ports; i++) begin
            pend_alu[i] = alu_req[i];
            pend_alu[i].en = alu_req[i].en && !reset;
        end
        pend_alu[0].en = pend_alu[0].en && !csr_req.en;  // csr takes slot 0
        pend_alu[1].en = pend_alu[1].en && !mul_req.en;
        pend_csr = csr_req;
        pend_csr.en = csr_req.en && !reset;
        pend_mul = mul_req;
        pend_mul.en = mul_req.en && !reset;
        for (int i = 0; i < load_ports; i++) begin
            pend_load[i] = load_req[i];
            pend_load[i].en = load_req[i].en && !reset;
        end
        for (int i = 0; i < store_ports; i++) begin
            pend_store[i] = store_req[i];
            pend_store[i].en = store_req[i].en && !reset;
        end
        checking = 1'b1;
    end

    task automatic check_result(input string who, input logic exp_v, input logic act_v,
                                input regread_pkg::data_t exp_d1, input regread_pkg::data_t act_d1,
                                input regread_pkg::data_t exp_d2, input regread_pkg::data_t act_d2);
        check_count++;
        if (act_v !== exp_v) begin
            error_count++;
            $display("%s: %s %s", pend_test, who, exp_v ? "gave no valid for an accepted request"
                : "raised valid without an accepted request");
        end else if (exp_v && act_d1 !== exp_d1) begin
            error_count++;
            $display("CHECK FAILED %s %s.d1: expected %h actual %h", pend_test, who, exp_d1, act_d1);
        end else if (exp_v && act_d2 !== exp_d2) begin
            error_count++;
            $display("CHECK FAILED %s %s.d2: expected %h actual %h", pend_test, who, exp_d2, act_d2);
        end
    endtask

    always @(negedge clk) begin
        logic [alu_ports-1:0] exp_ready;
        if (checking) begin
            for (int i = 0; i < alu_ports; i++) begin
                check_result($sformatf("alu_opnd[%0d]", i), pend_alu[i].en, alu_opnd[i].valid,
                    expected_value(pend_alu[i].rs1), alu_opnd[i].d1,
                    expected_value(pend_alu[i].rs2), alu_opnd[i].d2);
            end
            check_result("csr_opnd", pend_csr.en, csr_opnd.valid, expected_value(pend_csr.rs1),
                csr_opnd.d1, expected_value(pend_csr.rs2), csr_opnd.d2);
            check_result("mul_opnd", pend_mul.en, mul_opnd.valid, expected_value(pend_mul.rs1),
                mul_opnd.d1, expected_value(pend_mul.rs2), mul_opnd.d2);
            for (int i = 0; i < load_ports; i++) begin
                check_result($sformatf("load_opnd[%0d]", i), pend_load[i].en, load_opnd[i].valid,
                    expected_value(pend_load[i].rs1), load_opnd[i].d1, '0, '0);
            end
            for (int i = 0; i < store_ports; i++) begin
                check_result($sformatf("store_opnd[%0d]", i), pend_store[i].en,
                    store_opnd[i].valid, expected_value(pend_store[i].rs1), store_opnd[i].d1,
                    expected_value(pend_store[i].rs2), store_opnd[i].d2);
            end
            exp_ready = '1;
            exp_ready[0] = ~csr_req.en;
            exp_ready[1] = ~mul_req.en;
            check_count++;
            if (alu_ready !== exp_ready || csr_ready !== 1'b1 || mul_ready !== 1'b1) begin
                error_count++;
                $display("CHECK FAILED %s ready: expected %b11 actual %b%b%b", test_name,
                    exp_ready, alu_ready, csr_ready, mul_ready);
            end
        end
        for (int w = 0; w < wb_ports; w++) begin  // the file takes these at the next edge
            if (!reset && wb[w].en && wb[w].we && wb[w].rd != '0) begin
                model[wb[w].rd] = wb[w].res;
            end
        end
        if (reset) begin
            for (int r = 0; r < preg_count; r++) begin
                model[r] = '0;
            end
        end
    end

    // **************************************************
    // stimulus
    // **************************************************

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic drive_idle();
        for (int i = 0; i < alu_ports; i++) alu_req[i] = '0;
        for (int i = 0; i < load_ports; i++) load_req[i] = '0;
        for (int i = 0; i < store_ports; i++) store_req[i] = '0;
        for (int w = 0; w < wb_ports; w++) wb[w] = '0;
        csr_req = '0;
        mul_req = '0;
    endtask

    task automatic random_reads();
        for (int i = 0; i < alu_ports; i++) alu_req[i] = {1'b1, rand_preg(), rand_preg()};
        for (int i = 0; i < load_ports; i++) load_req[i] = {1'b1, rand_preg()};
        for (int i = 0; i < store_ports; i++) store_req[i] = {1'b1, rand_preg(), rand_preg()};
    endtask

    task automatic read_all(input regread_pkg::preg_t r);
        for (int i = 0; i < alu_ports; i++) alu_req[i] = {1'b1, r, r};
        for (int i = 0; i < load_ports; i++) load_req[i] = {1'b1, r};
        for (int i = 0; i < store_ports; i++) store_req[i] = {1'b1, r, r};
    endtask

    task automatic random_writes();
        for (int w = 0; w < wb_ports; w++) wb[w] = {1'b1, rand_bit(), rand_preg(), rand_data()};
    endtask

    initial begin
        regread_pkg::preg_t r;
        lfsr_state = 16'd50105;
        error_count = 0;
        check_count = 0;
        checking = 1'b0;
        test_name = "reset";
        drive_idle();
        reset = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        #2;
        reset = 1'b0;

        test_name = "reset_read";
        for (int c = 0; c < zero_cycles; c++) begin
            random_reads();
            csr_req = {rand_bit(), rand_preg(), rand_preg()};
            mul_req = {rand_bit(), rand_preg(), rand_preg()};
            next_cycle();
        end

        test_name = "write_read";
        drive_idle();
        for (int c = 0; c < write_cycles; c++) begin
            random_writes();
            next_cycle();
        end
        drive_idle();
        wb[2] = {1'b1, 1'b1, 6'd0, rand_data()};  // write aimed at register 0
        next_cycle();
        drive_idle();
        read_all('0);
        next_cycle();
        for (int c = 0; c < read_cycles; c++) begin
            random_reads();
            next_cycle();
        end

        test_name = "bypass";
        for (int c = 0; c < bypass_rounds; c++) begin
            r = rand_preg();
            if (r == '0) r = 6'd1;
            drive_idle();
            read_all(r);
            next_cycle();
            drive_idle();
            wb[0] = {1'b1, 1'b1, r, rand_data()};
            wb[2] = {1'b1, 1'b1, r, rand_data()};
            wb[3] = {1'b1, 1'b0, r, rand_data()};  // enabled but not writing
            next_cycle();
        end

        test_name = "contend";
        drive_idle();
        random_reads();
        csr_req = {1'b1, rand_preg(), rand_preg()};
        next_cycle();
        csr_req = '0;  // the refused alu 0 request is held
        next_cycle();
        mul_req = {1'b1, rand_preg(), rand_preg()};
        next_cycle();
        mul_req = '0;
        next_cycle();
        csr_req = {1'b1, rand_preg(), rand_preg()};
        mul_req = {1'b1, rand_preg(), rand_preg()};
        next_cycle();
        drive_idle();
        next_cycle();

        test_name = "random";
        for (int c = 0; c < random_cycles; c++) begin
            random_reads();
            csr_req = {rand_bit(), rand_preg(), rand_preg()};
            mul_req = {rand_bit(), rand_preg(), rand_preg()};
            random_writes();
            next_cycle();
        end

        drive_idle();
        repeat (2) next_cycle();
        @(negedge clk);
        #1;
        $display("checks %0d, errors %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    initial begin
        #(total_cycles * clk_period);
        $display("watchdog expired after %0d cycles, the run did not finish", total_cycles);
        $display("Done: errors found");
        $finish;
    end

endmodule

`default_nettype wire

// File: bench/reg_read_props.sv
`timescale 1ns/1ps
`default_nettype none

module reg_read_props #(
    parameter int alu_ports = 3,
    parameter int load_ports = 2,
    parameter int store_ports = 1
) (
    input wire logic clk,
    input wire logic reset,
    input regread_pkg::src2_req_t alu_req [alu_ports],
    input regread_pkg::src2_req_t csr_req,
    input regread_pkg::src2_req_t mul_req,
    input regread_pkg::src1_req_t load_req [load_ports],
    input regread_pkg::src2_req_t store_req [store_ports],
    input wire logic [alu_ports-1:0] alu_ready,
    input regread_pkg::opnd2_t alu_opnd [alu_ports],
    input regread_pkg::opnd2_t csr_opnd,
    input regread_pkg::opnd2_t mul_opnd,
    input regread_pkg::opnd1_t load_opnd [load_ports],
    input regread_pkg::opnd2_t store_opnd [store_ports]
);

    localparam int clients = alu_ports + 2 + load_ports + store_ports;

    logic [clients-1:0] accepted;
    logic [clients-1:0] valid;

    // alu ports, then csr, mul, loads and stores
    always_comb begin
        for (int i = 0; i < alu_ports; i++) begin
            accepted[i] = alu_req[i].en && alu_ready[i];
            valid[i] = alu_opnd[i].valid;
        end
        accepted[alu_ports] = csr_req.en;
        valid[alu_ports] = csr_opnd.valid;
        accepted[alu_ports+1] = mul_req.en;
        valid[alu_ports+1] = mul_opnd.valid;
        for (int i = 0; i < load_ports; i++) begin
            accepted[alu_ports+2+i] = load_req[i].en;
            valid[alu_ports+2+i] = load_opnd[i].valid;
        end
        for (int i = 0; i < store_ports; i++) begin
            accepted[alu_ports+2+load_ports+i] = store_req[i].en;
            valid[alu_ports+2+load_ports+i] = store_opnd[i].valid;
        end
    end

    a_slot0_ready: assert property (@(posedge clk) disable iff (reset) alu_ready[0] == !csr_req.en)
        else $error("alu_ready[0] does not follow csr_req.en");

    for (genvar c = 0; c < clients; c++) begin : g_client
        a_next_valid: assert property (@(posedge clk) disable iff (reset) accepted[c] |=> valid[c])
            else $error("client %0d gave no valid after an accepted request", c);
    end

    a_quiet_after_reset: assert property (@(posedge clk) reset |=> valid == '0)
        else $error("valid raised in the cycle after reset");

endmodule

bind reg_read_top reg_read_props #(
    .alu_ports(alu_ports),
    .load_ports(load_ports),
    .store_ports(store_ports)
) u_props (
    .clk(clk),
    .reset(reset),
    .alu_req(alu_req),
    .csr_req(csr_req),
    .mul_req(mul_req),
    .load_req(load_req),
    .store_req(store_req),
    .alu_ready(alu_ready),
    .alu_opnd(alu_opnd),
    .csr_opnd(csr_opnd),
    .mul_opnd(mul_opnd),
    .load_opnd(load_opnd),
    .store_opnd(store_opnd)
);

`default_nettype wire

// File: logic/reg_read_top.sv
`timescale 1ns/1ps
`default_nettype none

module reg_read_top #(
    parameter int alu_ports = 3,
    parameter int load_ports = 2,
    parameter int store_ports = 1,
    parameter int wb_ports = 4,
    parameter int preg_count = 64
) (
    input wire logic clk,
    input wire logic reset,
    input regread_pkg::src2_req_t alu_req [alu_ports],
    input regread_pkg::src2_req_t csr_req,
    input regread_pkg::src2_req_t mul_req,
    input regread_pkg::src1_req_t load_req [load_ports],
    input regread_pkg::src2_req_t store_req [store_ports],
    output logic [alu_ports-1:0] alu_ready,
    output logic csr_ready,
    output logic mul_ready,
    input regread_pkg::wb_t wb [wb_ports],
    output regread_pkg::opnd2_t alu_opnd [alu_ports],
    output regread_pkg::opnd2_t csr_opnd,
    output regread_pkg::opnd2_t mul_opnd,
    output regread_pkg::opnd1_t load_opnd [load_ports],
    output regread_pkg::opnd2_t store_opnd [store_ports]
);

    localparam int rd_ports = 2 * alu_ports + load_ports + 2 * store_ports;

    logic [rd_ports-1:0] rd_en;
    regread_pkg::preg_t rd_addr [rd_ports];
    regread_pkg::data_t rd_data [rd_ports];
    regread_pkg::owner_t owner [2];

    read_select #(
        .alu_ports(alu_ports),
        .load_ports(load_ports),
        .store_ports(store_ports)
    ) u_read_select (
        .clk(clk),
        .reset(reset),
        .alu_req(alu_req),
        .csr_req(csr_req),
        .mul_req(mul_req),
        .load_req(load_req),
        .store_req(store_req),
        .alu_ready(alu_ready),
        .csr_ready(csr_ready),
        .mul_ready(mul_ready),
        .rd_en(rd_en),
        .rd_addr(rd_addr),
        .owner(owner)
    );

    preg_file #(
        .alu_ports(alu_ports),
        .load_ports(load_ports),
        .store_ports(store_ports),
        .wb_ports(wb_ports),
        .preg_count(preg_count)
    ) u_preg_file (
        .clk(clk),
        .reset(reset),
        .rd_en(rd_en),
        .rd_addr(rd_addr),
        .wb(wb),
        .rd_data(rd_data)
    );

    wb_bypass #(
        .alu_ports(alu_ports),
        .load_ports(load_ports),
        .store_ports(store_ports),
        .wb_ports(wb_ports)
    ) u_wb_bypass (
        .rd_en(rd_en),
        .rd_addr(rd_addr),
        .rd_data(rd_data),
        .owner(owner),
        .wb(wb),
        .alu_opnd(alu_opnd),
        .csr_opnd(csr_opnd),
        .mul_opnd(mul_opnd),
        .load_opnd(load_opnd),
        .store_opnd(store_opnd)
    );

endmodule

`default_nettype wire

// File: regfile/wb_bypass.sv
`timescale 1ns/1ps
`default_nettype none

module wb_bypass #(
    parameter int alu_ports = 3,
    parameter int load_ports = 2,
    parameter int store_ports = 1,
    parameter int wb_ports = 4
) (
    input wire logic [2*alu_ports+load_ports+2*store_ports-1:0] rd_en,
    input regread_pkg::preg_t rd_addr [2*alu_ports+load_ports+2*store_ports],
    input regread_pkg::data_t rd_data [2*alu_ports+load_ports+2*store_ports],
    input regread_pkg::owner_t owner [2],
    input regread_pkg::wb_t wb [wb_ports],
    output regread_pkg::opnd2_t alu_opnd [alu_ports],
    output regread_pkg::opnd2_t csr_opnd,
    output regread_pkg::opnd2_t mul_opnd,
    output regread_pkg::opnd1_t load_opnd [load_ports],
    output regread_pkg::opnd2_t store_opnd [store_ports]
);

    localparam int rd_ports = 2 * alu_ports + load_ports + 2 * store_ports;
    localparam int load_base = 2 * alu_ports;
    localparam int store_base = load_base + load_ports;

    regread_pkg::data_t byp_data [rd_ports];

    // **************************************************
    // same-cycle writeback forwarding
    // **************************************************

    always_comb begin
        for (int p = 0; p < rd_ports; p++) begin
            byp_data[p] = rd_data[p];
            for (int w = 0; w < wb_ports; w++) begin  // highest port is checked last and wins
                if (rd_en[p] && wb[w].en && wb[w].we && (wb[w].rd == rd_addr[p])
                    && (rd_addr[p] != '0)) begin
                    byp_data[p] = wb[w].res;
                end
            end
        end
    end

    // **************************************************
    // client results
    // **************************************************

    always_comb begin
        for (int i = 0; i < alu_ports; i++) begin
            alu_opnd[i].valid = rd_en[i];
            alu_opnd[i].d1 = byp_data[i];
            alu_opnd[i].d2 = byp_data[alu_ports+i];
        end
        // a borrowed slot produces no alu result
        alu_opnd[0].valid = rd_en[0] && (owner[0] == regread_pkg::OWN_ALU);
        alu_opnd[1].valid = rd_en[1] && (owner[1] == regread_pkg::OWN_ALU);

        csr_opnd.valid = rd_en[0] && (owner[0] == regread_pkg::OWN_CSR);
        csr_opnd.d1 = byp_data[0];
        csr_opnd.d2 = byp_data[alu_ports];
        mul_opnd.valid = rd_en[1] && (owner[1] == regread_pkg::OWN_MUL);
        mul_opnd.d1 = byp_data[1];
        mul_opnd.d2 = byp_data[alu_ports+1];

        for (int i = 0; i < load_ports; i++) begin
            load_opnd[i].valid = rd_en[load_base+i];
            load_opnd[i].d1 = byp_data[load_base+i];
        end
        for (int i = 0; i < store_ports; i++) begin
            store_opnd[i].valid = rd_en[store_base+2*i];
            store_opnd[i].d1 = byp_data[store_base+2*i];
            store_opnd[i].d2 = byp_data[store_base+2*i+1];
        end
    end

endmodule

`default_nettype wire

// File: regfile/preg_file.sv
`timescale 1ns/1ps
`default_nettype none

module preg_file #(
    parameter int alu_ports = 3,
    parameter int load_ports = 2,
    parameter int store_ports = 1,
    parameter int wb_ports = 4,
    parameter int preg_count = 64
) (
    input wire logic clk,
    input wire logic reset,
    input wire logic [2*alu_ports+load_ports+2*store_ports-1:0] rd_en,
    input regread_pkg::preg_t rd_addr [2*alu_ports+load_ports+2*store_ports],
    input regread_pkg::wb_t wb [wb_ports],
    output regread_pkg::data_t rd_data [2*alu_ports+load_ports+2*store_ports]
);

    localparam int rd_ports = 2 * alu_ports + load_ports + 2 * store_ports;

    regread_pkg::data_t regs [preg_count];
    logic [wb_ports-1:0] wr_hit;

    // **************************************************
    // write side
    // **************************************************

    // register 0 and numbers past the end of the array are never written
    always_comb begin
        for (int w = 0; w < wb_ports; w++) begin
            wr_hit[w] = wb[w].en && wb[w].we && (wb[w].rd != '0)
                && (int'(wb[w].rd) < preg_count);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int r = 0; r < preg_count; r++) begin
                regs[r] <= '0;
            end
        end else begin
            // later ports override earlier ones on the same rd
            for (int w = 0; w < wb_ports; w++) begin
                if (wr_hit[w]) begin
                    regs[wb[w].rd] <= wb[w].res;
                end
            end
        end
    end

    // **************************************************
    // read side
    // **************************************************

    always_comb begin
        for (int p = 0; p < rd_ports; p++) begin
            if (rd_en[p] && (rd_addr[p] != '0) && (int'(rd_addr[p]) < preg_count)) begin
                rd_data[p] = regs[rd_addr[p]];
            end else begin
                rd_data[p] = '0;  // idle port or the zero register
            end
        end
    end

endmodule

`default_nettype wire

// File: regfile/read_select.sv
`timescale 1ns/1ps
`default_nettype none

module read_select #(
    parameter int alu_ports = 3,
    parameter int load_ports = 2,
    parameter int store_ports = 1
) (
    input wire logic clk,
    input wire logic reset,
    input regread_pkg::src2_req_t alu_req [alu_ports],
    input regread_pkg::src2_req_t csr_req,
    input regread_pkg::src2_req_t mul_req,
    input regread_pkg::src1_req_t load_req [load_ports],
    input regread_pkg::src2_req_t store_req [store_ports],
    output logic [alu_ports-1:0] alu_ready,
    output logic csr_ready,
    output logic mul_ready,
    output logic [2*alu_ports+load_ports+2*store_ports-1:0] rd_en,
    output regread_pkg::preg_t rd_addr [2*alu_ports+load_ports+2*store_ports],
    output regread_pkg::owner_t owner [2]
);

    localparam int rd_ports = 2 * alu_ports + load_ports + 2 * store_ports;
    localparam int load_base = 2 * alu_ports;
    localparam int store_base = load_base + load_ports;

    logic [rd_ports-1:0] en_next;
    regread_pkg::preg_t addr_next [rd_ports];
    regread_pkg::owner_t owner_next [2];

    assign csr_ready = 1'b1;  // csr and mul never wait
    assign mul_ready = 1'b1;

    // **************************************************
    // slot grant and flat port layout
    // **************************************************

    always_comb begin
        regread_pkg::src2_req_t borrow;
        regread_pkg::owner_t own;

        alu_ready = '1;

        // all rs1 reads first, then all rs2 reads
        for (int i = 0; i < alu_ports; i++) begin
            en_next[i] = alu_req[i].en;
            en_next[alu_ports+i] = alu_req[i].en;
            addr_next[i] = alu_req[i].rs1;
            addr_next[alu_ports+i] = alu_req[i].rs2;
        end

        // slot 0 goes to csr, slot 1 to mul, the alu port is refused
        for (int s = 0; s < 2; s++) begin
            borrow = (s == 0) ? csr_req : mul_req;
            own = (s == 0) ? regread_pkg::OWN_CSR : regread_pkg::OWN_MUL;
            alu_ready[s] = ~borrow.en;
            if (borrow.en) begin
                en_next[s] = 1'b1;
                en_next[alu_ports+s] = 1'b1;
                addr_next[s] = borrow.rs1;
                addr_next[alu_ports+s] = borrow.rs2;
                owner_next[s] = own;
            end else begin
                owner_next[s] = alu_req[s].en ? regread_pkg::OWN_ALU : regread_pkg::OWN_NONE;
            end
        end

        for (int i = 0; i < load_ports; i++) begin
            en_next[load_base+i] = load_req[i].en;
            addr_next[load_base+i] = load_req[i].rs1;
        end

        // each store takes two neighbouring read ports
        for (int i = 0; i < store_ports; i++) begin
            en_next[store_base+2*i] = store_req[i].en;
            en_next[store_base+2*i+1] = store_req[i].en;
            addr_next[store_base+2*i] = store_req[i].rs1;
            addr_next[store_base+2*i+1] = store_req[i].rs2;
        end
    end

    // **************************************************
    // stage register
    // **************************************************

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_en <= '0;
            owner[0] <= regread_pkg::OWN_NONE;
            owner[1] <= regread_pkg::OWN_NONE;
        end else begin
            rd_en <= en_next;
            owner[0] <= owner_next[0];
            owner[1] <= owner_next[1];
        end
    end

    always_ff @(posedge clk) begin
        for (int p = 0; p < rd_ports; p++) begin
            rd_addr[p] <= addr_next[p];  // only looked at while rd_en is high
        end
    end

endmodule

`default_nettype wire

// File: common/regread_pkg.sv
`default_nettype none

package regread_pkg;

    // **************************************************
    // widths
    // **************************************************

    localparam int XLEN = 32;
    localparam int PREG_BITS = 6;

    typedef logic [PREG_BITS-1:0] preg_t;  // physical register number
    typedef logic [XLEN-1:0] data_t;

    // who held a shared ALU read slot in the previous cycle
    typedef logic [1:0] owner_t;

    localparam owner_t OWN_NONE = 2'd0;
    localparam owner_t OWN_ALU = 2'd1;
    localparam owner_t OWN_CSR = 2'd2;
    localparam owner_t OWN_MUL = 2'd3;

    // **************************************************
    // request side
    // **************************************************

    typedef struct packed {
        logic en;
        preg_t rs1;
        preg_t rs2;
    } src2_req_t;  // alu, csr, mul and store clients

    typedef struct packed {
        logic en;
        preg_t rs1;
    } src1_req_t;  // load clients

    // **************************************************
    // writeback and results
    // **************************************************

    typedef struct packed {
        logic en;
        logic we;  // the write only happens with en and we both high
        preg_t rd;
        data_t res;
    } wb_t;

    typedef struct packed {
        logic valid;
        data_t d1;
        data_t d2;
    } opnd2_t;

    typedef struct packed {
        logic valid;
        data_t d1;
    } opnd1_t;

endpackage

`default_nettype wire
